// File: Bender.yml
package:
  name: imu_spi_link

sources:
  - files:
      - verilog/spi_frame_pkg.sv
      - verilog/imu_sample_pkg.sv
      - verilog/spi_byte_receiver.sv
      - verilog/frame_capture.sv
      - verilog/imu_frame_decoder.sv
      - verilog/imu_spi_link.sv
  - target: simulation
    files:
      - tb/clock_gen.sv
      - tb/imu_spi_link_checker.sv
      - tb/tb_imu_spi_link.sv

// File: imu_spi_link.f
verilog/spi_frame_pkg.sv
verilog/imu_sample_pkg.sv
verilog/spi_byte_receiver.sv
verilog/frame_capture.sv
verilog/imu_frame_decoder.sv
verilog/imu_spi_link.sv
tb/clock_gen.sv
tb/imu_spi_link_checker.sv
tb/tb_imu_spi_link.sv

// File: tb/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic cs_n
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 4;

    // Free running system clock with a period of 10
    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // Reset is high from time zero and drops on a rising edge after 4 cycles
    initial begin
        cs_n <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        cs_n <= 1'b0;
    end

endmodule

// File: tb/imu_spi_link_checker.sv
module imu_spi_link_checker (
    input logic                   clk,
    input logic                   cs_n,
    input logic                   snapshot_strobe,
    input logic                   initialized,
    input logic                   error,
    input logic                   angle_valid,
    input logic                   rate_valid,
    input imu_sample_pkg::angle_t roll,
    input imu_sample_pkg::angle_t pitch,
    input imu_sample_pkg::angle_t yaw,
    input imu_sample_pkg::rate_t  gyro_x,
    input imu_sample_pkg::rate_t  gyro_y,
    input imu_sample_pkg::rate_t  gyro_z
);

    // Failed assertions, read back by the testbench at the end of the run
    int unsigned assert_errors = 0;

    logic [95:0] fields;
    logic [3:0]  status;

    assign fields = {roll, pitch, yaw, gyro_x, gyro_y, gyro_z};
    assign status = {initialized, error, angle_valid, rate_valid};

    // ====================
    // Snapshot rules
    // ====================
    // The strobe from frame_capture is a single cycle pulse
    strobe_single: assert property (@(posedge clk) disable iff (cs_n)
        snapshot_strobe |=> !snapshot_strobe)
    else begin
        assert_errors = assert_errors + 1;
        $error("snapshot_strobe was high on two consecutive cycles");
    end

    // Outputs only move on the cycle right after a strobe
    hold_between: assert property (@(posedge clk) disable iff (cs_n)
        !$past(snapshot_strobe) |-> ($stable(fields) && $stable(status)))
    else begin
        assert_errors = assert_errors + 1;
        $error("Decoder outputs changed without a snapshot strobe");
    end

    // ====================
    // Status rules
    // ====================
    status_exclusive: assert property (@(posedge clk) !(initialized && error))
    else begin
        assert_errors = assert_errors + 1;
        $error("initialized and error were both high");
    end

    // Everything reads as zero while the system reset is held
    reset_zero: assert property (@(posedge clk) cs_n |-> (status == '0 && fields == '0))
    else begin
        assert_errors = assert_errors + 1;
        $error("Decoder outputs were not zero during reset");
    end

endmodule

bind imu_frame_decoder imu_spi_link_checker u_decoder_checker (
    .clk             (clk),
    .cs_n            (cs_n),
    .snapshot_strobe (snapshot_strobe),
    .initialized     (initialized),
    .error           (error),
    .angle_valid     (angle_valid),
    .rate_valid      (rate_valid),
    .roll            (roll),
    .pitch           (pitch),
    .yaw             (yaw),
    .gyro_x          (gyro_x),
    .gyro_y          (gyro_y),
    .gyro_z          (gyro_z)
);

// File: tb/imu_spi_link_testdata.txt
# frame bytes 0..15 as 32 hex digits, bytes to send (decimal), expected initialized error
# angle_valid rate_valid, expected roll pitch yaw gyro_x gyro_y gyro_z (hex)
AA01230456078900AB00CD00EF030000 16 1 0 1 1 0123 0456 0789 00ab 00cd 00ef
55111122223333444455556666000000 16 0 1 1 1 0123 0456 0789 00ab 00cd 00ef
AA100020003000400050006000001234 16 1 0 0 0 1000 2000 3000 4000 5000 6000
AA7FFF7FFF7FFF7FFF7FFF7FFF030000 15 1 0 0 0 1000 2000 3000 4000 5000 6000
AA010102020303040405050606030000 17 1 0 0 0 1000 2000 3000 4000 5000 6000
AAFF388000C12C85EEFFFF8001010000 16 1 0 1 0 ff38 8000 c12c 85ee ffff 8001
AA9C40E000F0008000FF00A55A02FFFF 16 1 0 0 1 9c40 e000 f000 8000 ff00 a55a
AA8AD0FED4B1E0F830C000DEAD030000 16 1 0 1 1 8ad0 fed4 b1e0 f830 c000 dead
AAFFFFFFFE8001F0F0ABCD9000FC0000 16 1 0 0 0 ffff fffe 8001 f0f0 abcd 9000
00123412341234123412341234FF0000 16 0 1 0 0 ffff fffe 8001 f0f0 abcd 9000
AA777777777777777777777777030000 17 0 1 0 0 ffff fffe 8001 f0f0 abcd 9000
AA000100020003000400050006010000 16 1 0 1 0 0001 0002 0003 0004 0005 0006

// File: tb/tb_imu_spi_link.sv
module tb_imu_spi_link;

    localparam int max_gap            = 15;
    localparam int hold_cycles        = 12;
    localparam int watchdog_per_frame = 700;
    localparam int watchdog_margin    = 200;

    logic                   clk;
    logic                   cs_n;
    logic                   sck;
    logic                   ss_n;
    logic                   sdi;
    logic                   initialized;
    logic                   error;
    logic                   angle_valid;
    logic                   rate_valid;
    imu_sample_pkg::angle_t roll;
    imu_sample_pkg::angle_t pitch;
    imu_sample_pkg::angle_t yaw;
    imu_sample_pkg::rate_t  gyro_x;
    imu_sample_pkg::rate_t  gyro_y;
    imu_sample_pkg::rate_t  gyro_z;

    // One entry per data line, status packed as {initialized, error, angle_valid, rate_valid}
    logic [127:0] frame_q[$];
    int unsigned  count_q[$];
    logic [3:0]   status_q[$];
    logic [95:0]  fields_q[$];

    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned assert_fails;
    bit          loaded = 1'b0;

    clock_gen u_clock_gen (
        .clk  (clk),
        .cs_n (cs_n)
    );

    imu_spi_link u_imu_spi_link (
        .clk         (clk),
        .cs_n        (cs_n),
        .sck         (sck),
        .ss_n        (ss_n),
        .sdi         (sdi),
        .initialized (initialized),
        .error       (error),
        .angle_valid (angle_valid),
        .rate_valid  (rate_valid),
        .roll        (roll),
        .pitch       (pitch),
        .yaw         (yaw),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

    // ====================
    // SPI master
    // ====================
    // Mode 0 with a 4 clk sck period and sdi set up while sck is low
    task automatic send_frame(input logic [127:0] frame, input int unsigned nbytes);
        logic [7:0] tx_byte;
        int         b;
        int         i;
        @(posedge clk);
        ss_n <= 1'b0;
        @(posedge clk);
        for (b = 0; b < nbytes; b++) begin
            // A 17th byte simply repeats the frame from byte 0
            tx_byte = frame[127 - 8 * (b % 16) -: 8];
            for (i = 7; i >= 0; i--) begin
                sdi <= tx_byte[i];
                @(posedge clk);
                sck <= 1'b1;
                repeat (2) @(posedge clk);
                sck <= 1'b0;
                @(posedge clk);
            end
        end
        ss_n <= 1'b1;
    endtask

    // ====================
    // Output checks
    // ====================
    task automatic compare_output(input string name, input int frame_no,
                                  input logic [15:0] got, input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: frame %0d %s is %h (%0d), expected %h (%0d)",
                     $time, frame_no, name, got, $signed(got), expected, $signed(expected));
        end
    endtask

    task automatic check_outputs(input int frame_no, input logic [3:0] status,
                                 input logic [95:0] fields);
        compare_output("initialized", frame_no, 16'(initialized), 16'(status[3]));
        compare_output("error", frame_no, 16'(error), 16'(status[2]));
        compare_output("angle_valid", frame_no, 16'(angle_valid), 16'(status[1]));
        compare_output("rate_valid", frame_no, 16'(rate_valid), 16'(status[0]));
        compare_output("roll", frame_no, roll, fields[95:80]);
        compare_output("pitch", frame_no, pitch, fields[79:64]);
        compare_output("yaw", frame_no, yaw, fields[63:48]);
        compare_output("gyro_x", frame_no, gyro_x, fields[47:32]);
        compare_output("gyro_y", frame_no, gyro_y, fields[31:16]);
        compare_output("gyro_z", frame_no, gyro_z, fields[15:0]);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int           fd;
        int           code;
        int           line_no;
        int           n;
        string        line;
        logic [127:0] frame;
        int unsigned  nbytes;
        int unsigned  init_e;
        int unsigned  err_e;
        int unsigned  aval_e;
        int unsigned  rval_e;
        logic [15:0]  f_roll;
        logic [15:0]  f_pitch;
        logic [15:0]  f_yaw;
        logic [15:0]  f_gx;
        logic [15:0]  f_gy;
        logic [15:0]  f_gz;

        sck  <= 1'b0;
        ss_n <= 1'b1;
        sdi  <= 1'b0;
        void'($urandom(70620));

        fd = $fopen("tb/imu_spi_link_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file tb/imu_spi_link_testdata.txt");
        end
        line_no = 0;
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            line_no++;
            // Blank lines and lines starting with # carry no frame
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%h %d %d %d %d %d %h %h %h %h %h %h", frame, nbytes,
                               init_e, err_e, aval_e, rval_e,
                               f_roll, f_pitch, f_yaw, f_gx, f_gy, f_gz);
                if (code == 12) begin
                    frame_q.push_back(frame);
                    count_q.push_back(nbytes);
                    status_q.push_back({init_e[0], err_e[0], aval_e[0], rval_e[0]});
                    fields_q.push_back({f_roll, f_pitch, f_yaw, f_gx, f_gy, f_gz});
                end else begin
                    errors++;
                    $display("Test data line %0d could not be parsed", line_no);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        loaded = 1'b1;

        // Everything must come out of reset as zero
        wait (cs_n == 1'b0);
        @(posedge clk);
        check_outputs(0, 4'b0000, '0);

        for (n = 0; n < frame_q.size(); n++) begin
            repeat ($urandom % (max_gap + 1)) @(posedge clk);
            send_frame(frame_q[n], count_q[n]);
            // Outputs settle within 8 cycles of ss_n rising
            repeat (hold_cycles) @(posedge clk);
            check_outputs(n + 1, status_q[n], fields_q[n]);
        end

        assert_fails = u_imu_spi_link.u_imu_frame_decoder.u_decoder_checker.assert_errors;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Bound by the number of frames in the data file
    initial begin
        wait (loaded);
        repeat (frame_q.size() * watchdog_per_frame + watchdog_margin) @(posedge clk);
        $display("Timeout: the frames did not finish in the expected number of clk cycles");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog/frame_capture.sv
module frame_capture (
    input  logic                  clk,
    input  logic                  cs_n,
    input  logic                  ss_n,
    input  spi_frame_pkg::frame_t frame_buf,
    input  logic                  frame_full,
    output spi_frame_pkg::frame_t snapshot,
    output logic                  snapshot_strobe
);

    localparam int settle_w = $clog2(imu_sample_pkg::settle_cycles + 1);
    localparam logic [settle_w-1:0] settle_last = settle_w'(imu_sample_pkg::settle_cycles);

    logic [imu_sample_pkg::sync_stages-1:0] ss_sync;
    logic [imu_sample_pkg::sync_stages-1:0] full_sync;
    logic [settle_w-1:0]                    settle_cnt;
    logic                                   ss_high;
    logic                                   full_seen;
    logic                                   settled;
    logic                                   taken;
    logic                                   load;

    // ====================
    // Synchronisers
    // ====================
    // Both signals are static by the time they are used, so plain flop chains suffice
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            ss_sync   <= '0;
            full_sync <= '0;
        end else begin
            ss_sync   <= {ss_sync[imu_sample_pkg::sync_stages-2:0], ss_n};
            full_sync <= {full_sync[imu_sample_pkg::sync_stages-2:0], frame_full};
        end
    end

    assign ss_high   = ss_sync[imu_sample_pkg::sync_stages-1];
    assign full_seen = full_sync[imu_sample_pkg::sync_stages-1];

    // ====================
    // Settle and load
    // ====================
    assign settled = (settle_cnt == settle_last);
    // One copy per deselect period and only when a whole frame arrived
    assign load    = settled && full_seen && !taken;

    // Counts clk cycles since the synchronised slave select went high and saturates
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            settle_cnt <= '0;
        end else if (!ss_high) begin
            settle_cnt <= '0;
        end else if (!settled) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // Re-armed when the master selects us again for the next frame
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            taken <= 1'b0;
        end else if (!ss_high) begin
            taken <= 1'b0;
        end else if (load) begin
            taken <= 1'b1;
        end
    end

    // All 16 bytes move in the same cycle, the SCK side being idle by now
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            snapshot        <= '0;
            snapshot_strobe <= 1'b0;
        end else begin
            if (load) begin
                snapshot <= frame_buf;
            end
            // Strobe follows the load by one cycle so the snapshot is already stable
            snapshot_strobe <= load;
        end
    end

endmodule

// File: verilog/imu_frame_decoder.sv
module imu_frame_decoder (
    input  logic                   clk,
    input  logic                   cs_n,
    input  spi_frame_pkg::frame_t  snapshot,
    input  logic                   snapshot_strobe,
    output logic                   initialized,
    output logic                   error,
    output logic                   angle_valid,
    output logic                   rate_valid,
    output imu_sample_pkg::angle_t roll,
    output imu_sample_pkg::angle_t pitch,
    output imu_sample_pkg::angle_t yaw,
    output imu_sample_pkg::rate_t  gyro_x,
    output imu_sample_pkg::rate_t  gyro_y,
    output imu_sample_pkg::rate_t  gyro_z
);

    logic                                header_ok;
    logic [spi_frame_pkg::byte_bits-1:0] flags;

    // Joins the big-endian byte pair that starts at the given offset
    function automatic logic [15:0] field16(
        input spi_frame_pkg::frame_t f,
        input int unsigned           offset
    );
        return {f[offset], f[offset+1]};
    endfunction

    assign header_ok = (snapshot[0] == spi_frame_pkg::header_value);
    assign flags     = snapshot[spi_frame_pkg::flags_offset];

    // ====================
    // Status
    // ====================
    // Every strobe refreshes the status, good header or not
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            initialized <= 1'b0;
            error       <= 1'b0;
        end else if (snapshot_strobe) begin
            initialized <= header_ok;
            error       <= !header_ok;
        end
    end

    // ====================
    // Fields
    // ====================
    // A bad header leaves the last good sample and its valids in place
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            angle_valid <= 1'b0;
            rate_valid  <= 1'b0;
            roll        <= '0;
            pitch       <= '0;
            yaw         <= '0;
            gyro_x      <= '0;
            gyro_y      <= '0;
            gyro_z      <= '0;
        end else if (snapshot_strobe && header_ok) begin
            angle_valid <= flags[spi_frame_pkg::angle_flag_bit];
            rate_valid  <= flags[spi_frame_pkg::rate_flag_bit];
            // The byte pairs are two's complement so a plain cast keeps the sign
            roll   <= imu_sample_pkg::angle_t'(field16(snapshot, spi_frame_pkg::roll_offset));
            pitch  <= imu_sample_pkg::angle_t'(field16(snapshot, spi_frame_pkg::pitch_offset));
            yaw    <= imu_sample_pkg::angle_t'(field16(snapshot, spi_frame_pkg::yaw_offset));
            gyro_x <= imu_sample_pkg::rate_t'(field16(snapshot, spi_frame_pkg::gyro_x_offset));
            gyro_y <= imu_sample_pkg::rate_t'(field16(snapshot, spi_frame_pkg::gyro_y_offset));
            gyro_z <= imu_sample_pkg::rate_t'(field16(snapshot, spi_frame_pkg::gyro_z_offset));
        end
    end

endmodule

// File: verilog/imu_sample_pkg.sv
package imu_sample_pkg;

    // ====================
    // Sample types
    // ====================

    // Euler angle in 0.01 degree steps
    typedef logic signed [15:0] angle_t;

    // Angular rate as scaled by the sensor firmware
    typedef logic signed [15:0] rate_t;

    // ====================
    // Clock crossing
    // ====================

    // Flops in each synchroniser chain into the clk domain
    localparam int sync_stages = 2;

    // Cycles the synchronised slave select must stay high before the buffer is copied
    // so that the last SCK write has long settled
    localparam int settle_cycles = 3;

endpackage

// File: verilog/imu_spi_link.sv
module imu_spi_link (
    input  logic                   clk,
    input  logic                   cs_n,
    input  logic                   sck,
    input  logic                   ss_n,
    input  logic                   sdi,
    output logic                   initialized,
    output logic                   error,
    output logic                   angle_valid,
    output logic                   rate_valid,
    output imu_sample_pkg::angle_t roll,
    output imu_sample_pkg::angle_t pitch,
    output imu_sample_pkg::angle_t yaw,
    output imu_sample_pkg::rate_t  gyro_x,
    output imu_sample_pkg::rate_t  gyro_y,
    output imu_sample_pkg::rate_t  gyro_z
);

    // Frame held in the SCK domain
    spi_frame_pkg::frame_t frame_buf;
    logic                  frame_full;

    // Copy of the frame in the clk domain
    spi_frame_pkg::frame_t snapshot;
    logic                  snapshot_strobe;

    // ====================
    // SCK domain
    // ====================
    spi_byte_receiver u_spi_byte_receiver (
        .sck        (sck),
        .ss_n       (ss_n),
        .sdi        (sdi),
        .cs_n       (cs_n),
        .frame_buf  (frame_buf),
        .frame_full (frame_full)
    );

    // ====================
    // clk domain
    // ====================
    frame_capture u_frame_capture (
        .clk             (clk),
        .cs_n            (cs_n),
        .ss_n            (ss_n),
        .frame_buf       (frame_buf),
        .frame_full      (frame_full),
        .snapshot        (snapshot),
        .snapshot_strobe (snapshot_strobe)
    );

    imu_frame_decoder u_imu_frame_decoder (
        .clk             (clk),
        .cs_n            (cs_n),
        .snapshot        (snapshot),
        .snapshot_strobe (snapshot_strobe),
        .initialized     (initialized),
        .error           (error),
        .angle_valid     (angle_valid),
        .rate_valid      (rate_valid),
        .roll            (roll),
        .pitch           (pitch),
        .yaw             (yaw),
        .gyro_x          (gyro_x),
        .gyro_y          (gyro_y),
        .gyro_z          (gyro_z)
    );

endmodule

// File: verilog/spi_byte_receiver.sv
module spi_byte_receiver (
    input  logic                  sck,
    input  logic                  ss_n,
    input  logic                  sdi,
    input  logic                  cs_n,
    output spi_frame_pkg::frame_t frame_buf,
    output logic                  frame_full
);

    localparam int bit_index_bits = $clog2(spi_frame_pkg::byte_bits);
    localparam logic [bit_index_bits-1:0] last_bit =
        bit_index_bits'(spi_frame_pkg::byte_bits - 1);
    localparam logic [spi_frame_pkg::byte_index_bits-1:0] last_byte =
        spi_frame_pkg::byte_index_bits'(spi_frame_pkg::frame_bytes - 1);

    logic [bit_index_bits-1:0]                 bit_cnt;
    logic [spi_frame_pkg::byte_index_bits-1:0] byte_cnt;
    logic [spi_frame_pkg::byte_bits-2:0]       rx_shift;
    logic [spi_frame_pkg::byte_bits-1:0]       rx_byte;
    logic                                      overrun;
    logic                                      xfer_clr;
    logic                                      byte_done;
    logic                                      byte_start;

    // Counters restart whenever the master deselects us or the system is reset
    assign xfer_clr = cs_n | ss_n;

    // The eighth bit arrives on this edge and completes the byte
    assign byte_done  = (bit_cnt == last_bit);
    // True on the first bit of byte 0 and also of a 17th byte after the counter wraps
    assign byte_start = (bit_cnt == '0) && (byte_cnt == '0);
    // Mode 0 sends MSB first so the live bit is the LSB of the finished byte
    assign rx_byte    = {rx_shift, sdi};

    // ====================
    // Bit and byte counting
    // ====================
    always_ff @(posedge sck or posedge xfer_clr) begin
        if (xfer_clr) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rx_shift <= '0;
            overrun  <= 1'b0;
        end else if (byte_done) begin
            bit_cnt  <= '0;
            byte_cnt <= byte_cnt + 1'b1;
            // Once 16 bytes are in, anything more makes the frame invalid
            if (byte_cnt == last_byte) begin
                overrun <= 1'b1;
            end
        end else begin
            bit_cnt  <= bit_cnt + 1'b1;
            rx_shift <= rx_byte[spi_frame_pkg::byte_bits-2:0];
        end
    end

    // ====================
    // Frame buffer
    // ====================
    // The buffer outlives ss_n going high so the clk domain can copy it afterwards
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            frame_buf  <= '0;
            frame_full <= 1'b0;
        end else if (!ss_n) begin
            if (byte_done && !overrun) begin
                frame_buf[byte_cnt] <= rx_byte;
            end
            // Full only for an exact 16 byte frame
            if (byte_done && !overrun && (byte_cnt == last_byte)) begin
                frame_full <= 1'b1;
            end else if (byte_start) begin
                frame_full <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/spi_frame_pkg.sv
package spi_frame_pkg;

    // ====================
    // Frame geometry
    // ====================

    // Bytes in one sensor frame sent by the microcontroller
    localparam int frame_bytes = 16;

    // Bits per SPI byte
    localparam int byte_bits = 8;

    // Width of the byte counter in the SCK domain
    localparam int byte_index_bits = 4;

    // First byte of every good frame
    localparam logic [byte_bits-1:0] header_value = 8'hAA;

    // ====================
    // Field layout
    // ====================

    // Each 16-bit field is sent big-endian and these give the MSB byte
    localparam int roll_offset   = 1;
    localparam int pitch_offset  = 3;
    localparam int yaw_offset    = 5;
    localparam int gyro_x_offset = 7;
    localparam int gyro_y_offset = 9;
    localparam int gyro_z_offset = 11;
    localparam int flags_offset  = 13;

    // Bits inside the flags byte
    localparam int angle_flag_bit = 0;
    localparam int rate_flag_bit  = 1;

    // Byte 0 sits in the most significant position of the packed frame
    typedef logic [0:frame_bytes-1][byte_bits-1:0] frame_t;

endpackage
